/* include/tcu_exc_defs.svh */
// ------------------------------
// Tensor-core exception path sizes
// Lane count, word width and elements per word
// ------------------------------

`ifndef TCU_EXC_DEFS_SVH
`define TCU_EXC_DEFS_SVH

// Number of 32-bit lanes per operand
`define TCU_EXC_LANES 8

// Width of one packed lane word
`define TCU_EXC_WORD_W 32

// Widest packing, four 8-bit elements per word
`define TCU_EXC_ELEMS 4

// ------------------------------
// Elements per word by format
// ------------------------------
`define TCU_EXC_ELEMS_FP16 2
`define TCU_EXC_ELEMS_BF16 2
`define TCU_EXC_ELEMS_FP8 4
`define TCU_EXC_ELEMS_BF8 4

`endif

/* verilog/tcu_exc_pkg.sv */
// ------------------------------
// Tensor-core exception types
// Format codes, element classes and stage records
// ------------------------------

`include "tcu_exc_defs.svh"

package tcu_exc_pkg;

    // Packed element formats, other codes are reserved
    typedef enum logic [2:0] {
        FMT_FP16 = 3'd0,
        FMT_BF16 = 3'd1,
        FMT_FP8  = 3'd2,
        FMT_BF8  = 3'd3
    } tcu_fmt_e;

    // Special-value class of one element
    typedef struct packed {
        logic sign;
        logic is_zero;
        logic is_inf;
        logic is_nan;
    } fedp_class_t;

    // Classes of the A and B elements of one lane
    // Slots past the format's element count stay zero
    typedef struct packed {
        fedp_class_t [`TCU_EXC_ELEMS-1:0] a;
        fedp_class_t [`TCU_EXC_ELEMS-1:0] b;
    } lane_cls_t;

    // ------------------------------
    // Decode to execute
    // ------------------------------
    typedef struct packed {
        logic                            valid;
        tcu_fmt_e                        fmt;
        logic [`TCU_EXC_LANES-1:0]       mask;
        lane_cls_t [`TCU_EXC_LANES-1:0]  lanes;
        fedp_class_t                     c_cls;
    } cls_stage_t;

    // Merged product flags of one lane
    typedef struct packed {
        logic nan;
        logic inf;
        logic sign;
    } prod_flags_t;

    // ------------------------------
    // Execute to result
    // ------------------------------
    typedef struct packed {
        logic                              valid;
        prod_flags_t [`TCU_EXC_LANES-1:0]  lanes;
        fedp_class_t                       c_cls;
    } prod_stage_t;

    // Final exception of A.B+C
    typedef struct packed {
        logic sign;
        logic is_nan;
        logic is_inf;
    } fedp_excep_t;

endpackage

/* verilog/tcu_exc_classify.sv */
// ------------------------------
// Exception path decode stage
// Splits lane words by format, classifies each
// element and C, registers the result
// ------------------------------

`timescale 1ns/10ps

`include "tcu_exc_defs.svh"

module tcu_exc_classify (
    input  logic                                            i_clk,
    input  logic                                            i_rst_n,
    input  logic                                            i_valid,
    input  tcu_exc_pkg::tcu_fmt_e                           i_fmt,
    input  logic [`TCU_EXC_LANES-1:0]                       i_vld_mask,
    input  logic [`TCU_EXC_LANES-1:0][`TCU_EXC_WORD_W-1:0]  i_a,
    input  logic [`TCU_EXC_LANES-1:0][`TCU_EXC_WORD_W-1:0]  i_b,
    input  logic [31:0]                                     i_c,
    output tcu_exc_pkg::cls_stage_t                         o_cls
);

    // Element widths per format
    localparam int FP16_W = `TCU_EXC_WORD_W / `TCU_EXC_ELEMS_FP16;
    localparam int BF16_W = `TCU_EXC_WORD_W / `TCU_EXC_ELEMS_BF16;
    localparam int FP8_W  = `TCU_EXC_WORD_W / `TCU_EXC_ELEMS_FP8;
    localparam int BF8_W  = `TCU_EXC_WORD_W / `TCU_EXC_ELEMS_BF8;

    // ------------------------------
    // Class functions
    // ------------------------------

    // IEEE style: all-ones exponent is inf or NaN
    function automatic tcu_exc_pkg::fedp_class_t ieee_cls(
        input logic sgn,
        input logic exp_ones,
        input logic exp_zero,
        input logic man_zero
    );
        tcu_exc_pkg::fedp_class_t cls;
        cls.sign    = sgn;
        cls.is_nan  = exp_ones & ~man_zero;
        cls.is_inf  = exp_ones & man_zero;
        cls.is_zero = exp_zero & man_zero;
        return cls;
    endfunction

    function automatic tcu_exc_pkg::fedp_class_t cls_fp16(input logic [15:0] v);
        return ieee_cls(v[15], &v[14:10], ~|v[14:10], ~|v[9:0]);
    endfunction

    function automatic tcu_exc_pkg::fedp_class_t cls_bf16(input logic [15:0] v);
        return ieee_cls(v[15], &v[14:7], ~|v[14:7], ~|v[6:0]);
    endfunction

    // E4M3 has no infinity and a single NaN code
    function automatic tcu_exc_pkg::fedp_class_t cls_fp8(input logic [7:0] v);
        tcu_exc_pkg::fedp_class_t cls;
        cls.sign    = v[7];
        cls.is_nan  = &v[6:0];
        cls.is_inf  = 1'b0;
        cls.is_zero = ~|v[6:0];
        return cls;
    endfunction

    function automatic tcu_exc_pkg::fedp_class_t cls_bf8(input logic [7:0] v);
        return ieee_cls(v[7], &v[6:2], ~|v[6:2], ~|v[1:0]);
    endfunction

    function automatic tcu_exc_pkg::fedp_class_t cls_fp32(input logic [31:0] v);
        return ieee_cls(v[31], &v[30:23], ~|v[30:23], ~|v[22:0]);
    endfunction

    // ------------------------------
    // Per-lane split and classify
    // ------------------------------
    tcu_exc_pkg::lane_cls_t [`TCU_EXC_LANES-1:0] lane_d;
    tcu_exc_pkg::cls_stage_t                     cls_d;

    for (genvar l = 0; l < `TCU_EXC_LANES; l++) begin : g_lane
        always_comb begin
            lane_d[l] = '0;
            case (i_fmt)
                tcu_exc_pkg::FMT_FP16: begin
                    for (int j = 0; j < `TCU_EXC_ELEMS_FP16; j++) begin
                        lane_d[l].a[j] = cls_fp16(i_a[l][FP16_W*j +: FP16_W]);
                        lane_d[l].b[j] = cls_fp16(i_b[l][FP16_W*j +: FP16_W]);
                    end
                end
                tcu_exc_pkg::FMT_BF16: begin
                    for (int j = 0; j < `TCU_EXC_ELEMS_BF16; j++) begin
                        lane_d[l].a[j] = cls_bf16(i_a[l][BF16_W*j +: BF16_W]);
                        lane_d[l].b[j] = cls_bf16(i_b[l][BF16_W*j +: BF16_W]);
                    end
                end
                tcu_exc_pkg::FMT_FP8: begin
                    for (int j = 0; j < `TCU_EXC_ELEMS_FP8; j++) begin
                        lane_d[l].a[j] = cls_fp8(i_a[l][FP8_W*j +: FP8_W]);
                        lane_d[l].b[j] = cls_fp8(i_b[l][FP8_W*j +: FP8_W]);
                    end
                end
                tcu_exc_pkg::FMT_BF8: begin
                    for (int j = 0; j < `TCU_EXC_ELEMS_BF8; j++) begin
                        lane_d[l].a[j] = cls_bf8(i_a[l][BF8_W*j +: BF8_W]);
                        lane_d[l].b[j] = cls_bf8(i_b[l][BF8_W*j +: BF8_W]);
                    end
                end
                // Reserved code leaves every slot clear
                default: lane_d[l] = '0;
            endcase
        end
    end

    always_comb begin
        cls_d.valid = i_valid;
        cls_d.fmt   = i_fmt;
        cls_d.mask  = i_vld_mask;
        cls_d.lanes = lane_d;
        cls_d.c_cls = cls_fp32(i_c);
    end

    // Stage register, only valid is cleared
    always_ff @(posedge i_clk) begin
        o_cls <= cls_d;
        if (!i_rst_n) begin
            o_cls.valid <= 1'b0;
        end
    end

endmodule

/* verilog/tcu_exc_products.sv */
// ------------------------------
// Exception path execute stage
// Forms element product flags and merges them
// into one flag set per lane, with masking
// ------------------------------

`timescale 1ns/10ps

`include "tcu_exc_defs.svh"

module tcu_exc_products (
    input  tcu_exc_pkg::cls_stage_t   i_cls,
    output tcu_exc_pkg::prod_stage_t  o_prod
);

    localparam int CNT_W = $clog2(`TCU_EXC_ELEMS + 1);

    // ------------------------------
    // Format decode
    // ------------------------------
    logic [CNT_W-1:0] n_elem;
    logic             fmt_ok;

    always_comb begin
        case (i_cls.fmt)
            tcu_exc_pkg::FMT_FP16: begin
                n_elem = CNT_W'(`TCU_EXC_ELEMS_FP16);
                fmt_ok = 1'b1;
            end
            tcu_exc_pkg::FMT_BF16: begin
                n_elem = CNT_W'(`TCU_EXC_ELEMS_BF16);
                fmt_ok = 1'b1;
            end
            tcu_exc_pkg::FMT_FP8: begin
                n_elem = CNT_W'(`TCU_EXC_ELEMS_FP8);
                fmt_ok = 1'b1;
            end
            tcu_exc_pkg::FMT_BF8: begin
                n_elem = CNT_W'(`TCU_EXC_ELEMS_BF8);
                fmt_ok = 1'b1;
            end
            default: begin
                n_elem = '0;
                fmt_ok = 1'b0;
            end
        endcase
    end

    tcu_exc_pkg::prod_flags_t [`TCU_EXC_LANES-1:0] flags;

    // ------------------------------
    // Per-lane merge
    // ------------------------------
    for (genvar l = 0; l < `TCU_EXC_LANES; l++) begin : g_lane
        tcu_exc_pkg::fedp_class_t [`TCU_EXC_ELEMS-1:0] cls_a;
        tcu_exc_pkg::fedp_class_t [`TCU_EXC_ELEMS-1:0] cls_b;
        logic [`TCU_EXC_ELEMS-1:0] e_use;
        logic [`TCU_EXC_ELEMS-1:0] e_nan;
        logic [`TCU_EXC_ELEMS-1:0] e_inf;
        logic [`TCU_EXC_ELEMS-1:0] e_sgn;
        logic lane_en;
        logic lane_pos;
        logic lane_neg;
        logic lane_nan;

        assign cls_a = i_cls.lanes[l].a;
        assign cls_b = i_cls.lanes[l].b;

        for (genvar j = 0; j < `TCU_EXC_ELEMS; j++) begin : g_elem
            assign e_use[j] = (j < n_elem);
            // NaN input, or inf times zero
            assign e_nan[j] = e_use[j] & (cls_a[j].is_nan | cls_b[j].is_nan
                            | (cls_a[j].is_inf & cls_b[j].is_zero)
                            | (cls_a[j].is_zero & cls_b[j].is_inf));
            assign e_inf[j] = e_use[j] & (cls_a[j].is_inf | cls_b[j].is_inf) & ~e_nan[j];
            assign e_sgn[j] = cls_a[j].sign ^ cls_b[j].sign;
        end

        assign lane_pos = |(e_inf & ~e_sgn);
        assign lane_neg = |(e_inf & e_sgn);

        // Opposite infinities inside the lane sum to NaN
        assign lane_nan = (|e_nan) | (lane_pos & lane_neg);
        assign lane_en  = i_cls.mask[l] & fmt_ok;

        assign flags[l].nan  = lane_en & lane_nan;
        assign flags[l].inf  = lane_en & (lane_pos | lane_neg) & ~lane_nan;
        assign flags[l].sign = lane_en & lane_neg & ~lane_pos;
    end

    always_comb begin
        o_prod.valid = i_cls.valid;
        o_prod.lanes = flags;
        o_prod.c_cls = i_cls.c_cls;
    end

endmodule

/* verilog/tcu_exc_aggregate.sv */
// ------------------------------
// Exception path result stage
// Merges lane flags with C and registers the result
// ------------------------------

`timescale 1ns/10ps

`include "tcu_exc_defs.svh"

module tcu_exc_aggregate (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  tcu_exc_pkg::prod_stage_t   i_prod,
    output logic                       o_valid,
    output tcu_exc_pkg::fedp_excep_t   o_excep
);

    logic [`TCU_EXC_LANES-1:0] lane_nan;
    logic [`TCU_EXC_LANES-1:0] lane_pos;
    logic [`TCU_EXC_LANES-1:0] lane_neg;
    logic                      has_pos;
    logic                      has_neg;
    logic                      res_nan;
    tcu_exc_pkg::fedp_excep_t  excep_d;

    // ------------------------------
    // Split lanes by infinity sign
    // ------------------------------
    for (genvar l = 0; l < `TCU_EXC_LANES; l++) begin : g_lane
        assign lane_nan[l] = i_prod.lanes[l].nan;
        assign lane_pos[l] = i_prod.lanes[l].inf & ~i_prod.lanes[l].sign;
        assign lane_neg[l] = i_prod.lanes[l].inf & i_prod.lanes[l].sign;
    end

    // C joins the sum as one more term
    assign has_pos = (|lane_pos) | (i_prod.c_cls.is_inf & ~i_prod.c_cls.sign);
    assign has_neg = (|lane_neg) | (i_prod.c_cls.is_inf & i_prod.c_cls.sign);

    assign res_nan = (|lane_nan) | i_prod.c_cls.is_nan | (has_pos & has_neg);

    always_comb begin
        excep_d.sign   = has_neg & ~has_pos;
        excep_d.is_nan = res_nan;
        excep_d.is_inf = (has_pos | has_neg) & ~res_nan;
    end

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_excep <= '0;
        end else begin
            o_valid <= i_prod.valid;
            // Hold last result between operations
            if (i_prod.valid) begin
                o_excep <= excep_d;
            end
        end
    end

endmodule

/* verilog/tcu_exc_top.sv */
// ------------------------------
// Tensor-core special-value path
// Reports NaN or signed infinity of A.B+C
// in two cycles, one issue per cycle
// ------------------------------

`timescale 1ns/10ps

`include "tcu_exc_defs.svh"

module tcu_exc_top (
    input  logic                                            i_clk,
    input  logic                                            i_rst_n,
    input  logic                                            i_valid,
    input  tcu_exc_pkg::tcu_fmt_e                           i_fmt,
    input  logic [`TCU_EXC_LANES-1:0]                       i_vld_mask,
    input  logic [`TCU_EXC_LANES-1:0][`TCU_EXC_WORD_W-1:0]  i_a,
    input  logic [`TCU_EXC_LANES-1:0][`TCU_EXC_WORD_W-1:0]  i_b,
    input  logic [31:0]                                     i_c,
    output logic                                            o_valid,
    output tcu_exc_pkg::fedp_excep_t                        o_excep
);

    // Stage records
    tcu_exc_pkg::cls_stage_t  cls_s;
    tcu_exc_pkg::prod_stage_t prod_s;

    // ------------------------------
    // Decode, registered
    // ------------------------------
    tcu_exc_classify u_classify (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_fmt      (i_fmt),
        .i_vld_mask (i_vld_mask),
        .i_a        (i_a),
        .i_b        (i_b),
        .i_c        (i_c),
        .o_cls      (cls_s)
    );

    // Execute, combinational
    tcu_exc_products u_products (
        .i_cls  (cls_s),
        .o_prod (prod_s)
    );

    // ------------------------------
    // Result, registered
    // ------------------------------
    tcu_exc_aggregate u_aggregate (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_prod  (prod_s),
        .o_valid (o_valid),
        .o_excep (o_excep)
    );

endmodule

/* test/tb_tcu_exc_top.sv */
// ------------------------------
// Testbench for the tensor-core special-value path
// Random operands from a fixed seed, checked
// against a behavioral model of the exception rules
// ------------------------------

`timescale 1ns/10ps

`include "tcu_exc_defs.svh"

module tb_tcu_exc_top;

    localparam int LANES = `TCU_EXC_LANES;

    logic                   i_clk;
    logic                   i_rst_n;
    logic                   i_valid;
    tcu_exc_pkg::tcu_fmt_e  i_fmt;
    logic [LANES-1:0]       i_vld_mask;
    logic [LANES-1:0][31:0] i_a;
    logic [LANES-1:0][31:0] i_b;
    logic [31:0]            i_c;
    logic                   o_valid;
    tcu_exc_pkg::fedp_excep_t o_excep;

    // Operands under construction
    logic [LANES-1:0][31:0] a_w;
    logic [LANES-1:0][31:0] b_w;
    logic [31:0]            c_w;
    integer                 seed;
    int                     cyc;
    int                     checks;
    int                     errors;
    bit                     late;
    logic [2:0]             held;
    logic [2:0]             exp_q[$];
    int                     cyc_q[$];

    tcu_exc_top u_dut (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_fmt      (i_fmt),
        .i_vld_mask (i_vld_mask),
        .i_a        (i_a),
        .i_b        (i_b),
        .i_c        (i_c),
        .o_valid    (o_valid),
        .o_excep    (o_excep)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    always @(posedge i_clk) cyc = cyc + 1;

    // ------------------------------
    // Model of the exception rules
    // ------------------------------
    function automatic int urand(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Exponent and mantissa widths
    // Element count n is 0 for a reserved code
    function automatic void fmt_shape(input logic [2:0] fmt, output int ew, output int mw,
                                      output int n);
        ew = 4;
        mw = 3;
        n  = 0;
        case (fmt)
            3'd0: begin
                ew = 5;
                mw = 10;
                n  = 2;
            end
            3'd1: begin
                ew = 8;
                mw = 7;
                n  = 2;
            end
            3'd2: begin
                ew = 4;
                mw = 3;
                n  = 4;
            end
            3'd3: begin
                ew = 5;
                mw = 2;
                n  = 4;
            end
            default: n = 0;
        endcase
    endfunction

    // Returns {sign, zero, inf, nan}
    function automatic logic [3:0] classify_val(input logic [31:0] v, input int ew,
                                                input int mw, input bit e4m3);
        int emax;
        int mmax;
        int ex;
        int mn;
        logic [3:0] k;
        emax = (1 << ew) - 1;
        mmax = (1 << mw) - 1;
        ex   = (v >> mw) & emax;
        mn   = v & mmax;
        k[3] = v[ew+mw];
        k[2] = (ex == 0) && (mn == 0);
        k[1] = !e4m3 && (ex == emax) && (mn == 0);
        k[0] = e4m3 ? ((ex == emax) && (mn == mmax)) : ((ex == emax) && (mn != 0));
        return k;
    endfunction

    // Expected {sign, is_nan, is_inf} of A.B+C
    function automatic logic [2:0] model_excep(input logic [2:0] fmt,
                                               input logic [LANES-1:0] mask,
                                               input logic [LANES-1:0][31:0] a,
                                               input logic [LANES-1:0][31:0] b,
                                               input logic [31:0] c);
        int ew;
        int mw;
        int n;
        int w;
        logic [3:0] ka;
        logic [3:0] kb;
        logic [3:0] kc;
        bit any_nan;
        bit pos;
        bit neg;
        bit lp;
        bit ln;
        bit lnan;
        any_nan = 0;
        pos = 0;
        neg = 0;
        fmt_shape(fmt, ew, mw, n);
        w = (n == 0) ? 32 : 32 / n;
        for (int l = 0; l < LANES; l++) begin
            lp = 0;
            ln = 0;
            lnan = 0;
            for (int j = 0; j < n && mask[l]; j++) begin
                ka = classify_val((a[l] >> (j * w)) & ((1 << w) - 1), ew, mw, fmt == 3'd2);
                kb = classify_val((b[l] >> (j * w)) & ((1 << w) - 1), ew, mw, fmt == 3'd2);
                if (ka[0] | kb[0] | (ka[1] & kb[2]) | (ka[2] & kb[1])) begin
                    lnan = 1;
                end else if (ka[1] | kb[1]) begin
                    if (ka[3] ^ kb[3]) begin
                        ln = 1;
                    end else begin
                        lp = 1;
                    end
                end
            end
            if (lnan || (lp && ln)) begin
                any_nan = 1;
            end else begin
                pos |= lp;
                neg |= ln;
            end
        end
        kc = classify_val(c, 8, 23, 0);
        any_nan |= kc[0];
        if (kc[1]) begin
            if (kc[3]) begin
                neg = 1;
            end else begin
                pos = 1;
            end
        end
        any_nan |= pos & neg;
        return {neg & ~pos, any_nan, (pos | neg) & ~any_nan};
    endfunction

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    // Kind 0 finite, 1 zero, 2 inf, 3 NaN, 4 finite nonzero
    function automatic logic [31:0] make_val(input int ew, input int mw, input bit e4m3,
                                             input int kind, input logic [31:0] r);
        int emax;
        int mmax;
        int ex;
        int mn;
        emax = (1 << ew) - 1;
        mmax = (1 << mw) - 1;
        ex = (r >> 8) & emax;
        mn = (r >> 16) & mmax;
        case (kind)
            1: begin
                ex = 0;
                mn = 0;
            end
            // E4M3 keeps this pattern finite
            2: begin
                ex = emax;
                mn = 0;
            end
            3: begin
                ex = emax;
                mn = e4m3 ? mmax : (mn | 1);
            end
            4: ex = 1 + (ex % (emax - 1));
            default: begin
                if (e4m3 && ex == emax && mn == mmax) mn = mmax - 1;
                if (!e4m3 && ex == emax) ex = emax - 1;
            end
        endcase
        return (32'(r[31]) << (ew + mw)) | (ex << mw) | mn;
    endfunction

    function automatic logic [31:0] make_elem(input logic [2:0] fmt, input int kind);
        int ew;
        int mw;
        int n;
        fmt_shape(fmt, ew, mw, n);
        return make_val(ew, mw, fmt == 3'd2, kind, $random(seed));
    endfunction

    task automatic put_elem(input bit to_a, input int l, input int j, input int w,
                            input logic [31:0] e);
        logic [31:0] fld;
        fld = ((1 << w) - 1) << (j * w);
        if (to_a)
            a_w[l] = (a_w[l] & ~fld) | (e << (j * w));
        else
            b_w[l] = (b_w[l] & ~fld) | (e << (j * w));
    endtask

    // Specials land only in selected lanes
    // pct is the percentage of special elements
    task automatic fill_lanes(input logic [2:0] fmt, input int pct,
                              input logic [LANES-1:0] sel, input int base);
        int ew;
        int mw;
        int n;
        fmt_shape(fmt, ew, mw, n);
        if (n == 0) n = 4;
        for (int l = 0; l < LANES; l++)
            for (int j = 0; j < n; j++) begin
                put_elem(1, l, j, 32 / n, make_elem(fmt, (sel[l] && urand(100) < pct) ?
                                                         1 + urand(3) : base));
                put_elem(0, l, j, 32 / n, make_elem(fmt, (sel[l] && urand(100) < pct) ?
                                                         1 + urand(3) : base));
            end
    endtask

    task automatic step();
        @(posedge i_clk);
        #1;
    endtask

    task automatic issue_op(input logic [2:0] fmt, input logic [LANES-1:0] mask);
        i_valid    = 1'b1;
        i_fmt      = tcu_exc_pkg::tcu_fmt_e'(fmt);
        i_vld_mask = mask;
        i_a        = a_w;
        i_b        = b_w;
        i_c        = c_w;
        exp_q.push_back(model_excep(fmt, mask, a_w, b_w, c_w));
        cyc_q.push_back(cyc);
        step();
        i_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            step();
            n++;
        end
        assert (exp_q.size() == 0) else begin
            $display("gave up waiting for o_valid, %0d operations never completed",
                     exp_q.size());
            errors++;
            exp_q.delete();
            cyc_q.delete();
        end
    endtask

    task automatic end_test(input string name, input int chk0, input int err0);
        $display("test %s done: %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    // ------------------------------
    // Result monitor
    // ------------------------------
    always @(negedge i_clk) begin
        late = exp_q.size() != 0 && cyc > cyc_q[0] + 2;
        if (o_valid === 1'b1) begin
            assert (exp_q.size() != 0) else begin
                $display("o_valid went high at %0t with no operation outstanding", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                checks++;
                assert (cyc == cyc_q[0] + 2) else begin
                    $display("error at %0t: latency %0d cycles, expected 2", $time,
                             cyc - cyc_q[0]);
                    errors++;
                end
                assert (o_excep === exp_q[0]) else begin
                    $display("error at %0t: sign/nan/inf %b, expected %b", $time, o_excep,
                             exp_q[0]);
                    errors++;
                end
                held = exp_q[0];
                void'(exp_q.pop_front());
                void'(cyc_q.pop_front());
            end
        end else begin
            assert (!late) else begin
                $display("o_valid did not arrive for the operation issued in cycle %0d",
                         cyc_q[0]);
                errors++;
                void'(exp_q.pop_front());
                void'(cyc_q.pop_front());
            end
            // Result holds between operations
            if (i_rst_n === 1'b1) begin
                assert (o_excep === held) else begin
                    $display("error at %0t: o_excep %b changed while o_valid low, expected %b",
                             $time, o_excep, held);
                    errors++;
                end
            end
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int chk0;
        int err0;
        int f;
        int lane;
        seed       = 32'h595b_c3c0;
        held       = '0;
        i_rst_n    = 1'b0;
        i_valid    = 1'b0;
        i_fmt      = tcu_exc_pkg::FMT_FP16;
        i_vld_mask = '0;
        i_a        = '0;
        i_b        = '0;
        i_c        = '0;
        c_w        = '0;

        chk0 = checks;
        err0 = errors;
        for (int i = 0; i < 30; i++) begin
            step();
            if (i == 9) i_rst_n = 1'b1;
            checks++;
            assert (o_valid === 1'b0) else begin
                $display("error at %0t: o_valid high with nothing issued", $time);
                errors++;
            end
            checks++;
            assert (o_excep === 3'b000) else begin
                $display("error at %0t: o_excep %b after reset, expected 000", $time,
                         o_excep);
                errors++;
            end
        end
        end_test("reset", chk0, err0);

        // Finite operands issued back to back
        chk0 = checks;
        err0 = errors;
        for (int i = 0; i < 64; i++) begin
            fill_lanes(i / 16, 0, '1, 0);
            c_w = make_val(8, 23, 0, 0, $random(seed));
            issue_op(i / 16, $random(seed));
        end
        drain();
        end_test("finite", chk0, err0);

        // NaN elements, NaN C and inf times zero pairs
        chk0 = checks;
        err0 = errors;
        for (int i = 0; i < 120; i++) begin
            f = i / 30;
            fill_lanes(f, 15, '1, 0);
            if (urand(100) < 30) begin
                lane = urand(LANES);
                put_elem(1, lane, 0, (f < 2) ? 16 : 8, make_elem(f, 2));
                put_elem(0, lane, 0, (f < 2) ? 16 : 8, make_elem(f, 1));
            end
            c_w = make_val(8, 23, 0, (urand(100) < 20) ? 3 : 0, $random(seed));
            issue_op(f, $random(seed));
        end
        drain();
        end_test("nan", chk0, err0);

        // Infinities of one or mixed signs
        chk0 = checks;
        err0 = errors;
        for (int i = 0; i < 60; i++) begin
            f = urand(3);
            if (f == 2) f = 3;
            fill_lanes(f, 0, '1, 4);
            for (int k = 1 + urand(3); k > 0; k--)
                put_elem(urand(2), urand(LANES), urand(2), (f < 2) ? 16 : 8, make_elem(f, 2));
            c_w = make_val(8, 23, 0, (urand(4) == 0) ? 2 : 4, $random(seed));
            issue_op(f, (urand(4) == 0) ? $random(seed) : '1);
        end
        drain();
        end_test("infinity", chk0, err0);

        // Specials hidden behind the mask, then reserved codes
        chk0 = checks;
        err0 = errors;
        for (int i = 0; i < 60; i++) begin
            f = (i < 40) ? urand(4) : 4 + urand(4);
            i_vld_mask = $random(seed);
            fill_lanes(f, (i < 40) ? 50 : 40, (i < 40) ? ~i_vld_mask : '1, (i < 40) ? 4 : 0);
            c_w = make_val(8, 23, 0, (i < 40) ? 4 : urand(4), $random(seed));
            issue_op(f, i_vld_mask);
        end
        drain();
        end_test("mask", chk0, err0);

        // Random mix with gaps
        chk0 = checks;
        err0 = errors;
        for (int i = 0; i < 500; i++) begin
            f = (urand(10) < 8) ? urand(4) : 4 + urand(4);
            fill_lanes(f, urand(31), '1, 0);
            c_w = make_val(8, 23, 0, (urand(100) < 15) ? 1 + urand(3) : 0, $random(seed));
            issue_op(f, $random(seed));
            repeat (urand(4)) step();
        end
        drain();
        end_test("random", chk0, err0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* tcu_exc_top.f */
+incdir+include
verilog/tcu_exc_pkg.sv
verilog/tcu_exc_classify.sv
verilog/tcu_exc_products.sv
verilog/tcu_exc_aggregate.sv
verilog/tcu_exc_top.sv
test/tb_tcu_exc_top.sv

/* Bender.yml */
package:
  name: tcu_exc

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/tcu_exc_pkg.sv
      - verilog/tcu_exc_classify.sv
      - verilog/tcu_exc_products.sv
      - verilog/tcu_exc_aggregate.sv
      - verilog/tcu_exc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_tcu_exc_top.sv
